// ==== tb.f ====
common/tenyr_pkg.sv
source/wb_decoder.sv
memory/block_ram.sv
display/seg7_display.sv
source/tenyr_soc.sv
sim/tb_clock.sv
sim/tb_tenyr_soc.sv

// ==== Bender.yml ====
package:
  name: tenyr_soc

sources:
  - common/tenyr_pkg.sv
  - source/wb_decoder.sv
  - memory/block_ram.sv
  - display/seg7_display.sv
  - source/tenyr_soc.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_tenyr_soc.sv

// ==== sim/tb_tenyr_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tenyr_soc;

    import tenyr_pkg::*;

    logic        clk;
    logic        reset;
    wb_req_t     dbus_req;
    wb_rsp_t     dbus_rsp;
    wb_req_t     ibus_req;
    wb_rsp_t     ibus_rsp;
    logic [7:0]  seg;
    logic [3:0]  an;

    // Reference state of RAM and display registers.
    logic [31:0] ram_model [int unsigned];
    logic [15:0] value_m;
    logic [7:0]  ctrl_m;
    bit          traffic_done;

    tb_clock clock_gen (
        .clk_o ( clk )
    );

    tenyr_soc uut (
        .clk        ( clk      ),
        .reset_i    ( reset    ),
        .dbus_req_i ( dbus_req ),
        .dbus_rsp_o ( dbus_rsp ),
        .ibus_req_i ( ibus_req ),
        .ibus_rsp_o ( ibus_rsp ),
        .seg_o      ( seg      ),
        .an_o       ( an       )
    );

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("** Error at time %0t: %s, got %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    // Standard hex font, active low, gfedcba.
    function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old,
                                                input logic [31:0] dat,
                                                input logic [3:0]  sel);
        logic [31:0] word;
        word = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (sel[lane]) begin
                word[8*lane +: 8] = dat[8*lane +: 8];
            end
        end
        return word;
    endfunction

    // Called 1 ns after an edge, returns 1 ns after the idle cycle that follows ack.
    task automatic data_access(input logic [31:0] adr, input logic we,
                               input logic [31:0] dat, input logic [3:0] sel,
                               output logic [31:0] rd);
        int cycles;
        dbus_req.adr = adr;
        dbus_req.dat = dat;
        dbus_req.we  = we;
        dbus_req.sel = sel;
        dbus_req.stb = 1'b1;
        dbus_req.cyc = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!dbus_rsp.ack && cycles < 20);
        if (!dbus_rsp.ack) begin
            stop_on_failure("The data port gave no ack within 20 cycles.");
        end
        rd = dbus_rsp.dat;
        check_equal(cycles, 1, $sformatf("data ack latency at %h", adr));
        dbus_req = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic fetch_access(input logic [31:0] adr, output logic [31:0] rd);
        int cycles;
        ibus_req.adr = adr;
        ibus_req.dat = '0;
        ibus_req.we  = 1'b0;
        ibus_req.sel = 4'hF;
        ibus_req.stb = 1'b1;
        ibus_req.cyc = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ibus_rsp.ack && cycles < 20);
        if (!ibus_rsp.ack) begin
            stop_on_failure("The fetch port gave no ack within 20 cycles.");
        end
        rd = ibus_rsp.dat;
        check_equal(cycles, 1, $sformatf("fetch ack latency at %h", adr));
        ibus_req = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic ram_write(input int unsigned idx, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] rd;
        logic [31:0] old;
        data_access(RAM_BASE + idx, 1'b1, dat, sel, rd);
        old = ram_model.exists(idx) ? ram_model[idx] : 'x;
        ram_model[idx] = merge_lanes(old, dat, sel);
    endtask

    task automatic ram_read_check(input int unsigned idx);
        logic [31:0] rd;
        data_access(RAM_BASE + idx, 1'b0, 32'h0, 4'hF, rd);
        check_equal(rd, ram_model[idx], $sformatf("RAM read of word %0d", idx));
    endtask

    task automatic fetch_check(input int unsigned idx);
        logic [31:0] rd;
        fetch_access(RAM_BASE + idx, rd);
        check_equal(rd, ram_model[idx], $sformatf("fetch of word %0d", idx));
    endtask

    // Value register takes lanes 0 and 1, control register lane 0.
    task automatic seg_write(input logic offset, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] rd;
        data_access(SEG7_BASE + offset, 1'b1, dat, sel, rd);
        if (!offset) begin
            if (sel[0]) begin
                value_m[7:0] = dat[7:0];
            end
            if (sel[1]) begin
                value_m[15:8] = dat[15:8];
            end
        end else if (sel[0]) begin
            ctrl_m = dat[7:0];
        end
    endtask

    task automatic seg_read_check(input logic offset);
        logic [31:0] rd;
        data_access(SEG7_BASE + offset, 1'b0, 32'h0, 4'hF, rd);
        if (!offset) begin
            check_equal(rd, {16'b0, value_m}, "display value read-back");
        end else begin
            check_equal(rd, {24'b0, ctrl_m}, "display control read-back");
        end
    endtask

    task automatic unmapped_access(input logic [31:0] adr, input logic we,
                                   input logic [31:0] dat);
        logic [31:0] rd;
        data_access(adr, we, dat, 4'hF, rd);
        if (!we) begin
            check_equal(rd, 32'h0, $sformatf("unmapped read at %h", adr));
        end
    endtask

    // Four full rotations, so every digit is seen the same number of cycles.
    task automatic scan_check();
        int seen [4];
        int dark;
        int k;
        int per_digit;
        per_digit = 1 << (SCAN_DIV_BITS + 2);
        dark = 0;
        for (int d = 0; d < 4; d++) begin
            seen[d] = 0;
        end
        for (int n = 0; n < 4 * per_digit; n++) begin
            @(posedge clk);
            #1;
            if (an === 4'hF) begin
                dark++;
            end else begin
                k = -1;
                for (int d = 0; d < 4; d++) begin
                    if (an === ~(4'b0001 << d)) begin
                        k = d;
                    end
                end
                if (k < 0) begin
                    stop_on_failure("The anode outputs drive more than one digit.");
                end
                seen[k]++;
                check_equal(seg, {~ctrl_m[4+k], seg_pattern(value_m[4*k +: 4])},
                            $sformatf("segments of digit %0d", k));
            end
        end
        for (int d = 0; d < 4; d++) begin
            check_equal(seen[d], ctrl_m[d] ? 0 : per_digit,
                        $sformatf("active cycles of digit %0d", d));
        end
        check_equal(dark, per_digit * $countones(ctrl_m[3:0]), "cycles with no anode");
    endtask

    task automatic reset_state();
        logic [31:0] rd;
        check_equal(dbus_rsp.ack, 1'b0, "data ack in reset");
        check_equal(ibus_rsp.ack, 1'b0, "fetch ack in reset");
        reset = 1'b0;
        check_equal(an, 4'b1110, "anodes after reset");
        check_equal(seg, {1'b1, seg_pattern(4'h0)}, "segments after reset");
        value_m = '0;
        ctrl_m  = '0;
        data_access(RAM_BASE, 1'b0, 32'h0, 4'hF, rd);
    endtask

    task automatic ram_access_sweep();
        int unsigned idx;
        ram_write(0, 32'h0123_4567, 4'hF);
        ram_read_check(0);
        ram_write(RAM_WORDS - 1, 32'h89AB_CDEF, 4'hF);
        ram_read_check(RAM_WORDS - 1);
        ram_write(0, 32'hFFFF_00AA, 4'b0101);
        ram_read_check(0);
        ram_write(RAM_WORDS - 1, 32'h5A5A_5A5A, 4'b1000);
        ram_read_check(RAM_WORDS - 1);
        for (int n = 0; n < 24; n++) begin
            idx = $urandom_range(0, RAM_WORDS - 1);
            ram_write(idx, $urandom, 4'hF);
            ram_write(idx, $urandom, $urandom_range(1, 14));
            ram_read_check(idx);
        end
    endtask

    // Words 16 to 23 serve as the code region.
    task automatic fetch_after_write();
        logic [31:0] old;
        logic [31:0] rd;
        for (int n = 0; n < 8; n++) begin
            ram_write(16 + n, $urandom, 4'hF);
        end
        for (int n = 0; n < 8; n++) begin
            fetch_check(16 + n);
        end
        old = ram_model[20];
        fork
            ram_write(20, ~old, 4'hF);
            fetch_access(RAM_BASE + 20, rd);
        join
        check_equal(rd, old, "fetch colliding with a data write");
        fetch_check(20);
    endtask

    task automatic display_registers();
        seg_write(1'b0, 32'h1234_ABCD, 4'hF);
        seg_read_check(1'b0);
        seg_write(1'b0, 32'hFFFF_5600, 4'b0010);
        seg_read_check(1'b0);
        seg_write(1'b0, 32'h7777_7777, 4'b1100);
        seg_read_check(1'b0);
        seg_write(1'b1, 32'h0000_00A5, 4'b0001);
        seg_read_check(1'b1);
        seg_write(1'b1, 32'hFFFF_FFFF, 4'b1110);
        seg_read_check(1'b1);
        scan_check();
        seg_write(1'b0, 32'h0000_9E07, 4'b0011);
        seg_write(1'b1, 32'h0000_0030, 4'b0001);
        seg_read_check(1'b0);
        seg_read_check(1'b1);
        scan_check();
    endtask

    task automatic unmapped_space();
        logic [31:0] holes [4];
        holes[0] = 32'h0;
        holes[1] = SEG7_BASE + 2;
        holes[2] = RAM_BASE + RAM_WORDS;
        holes[3] = RAM_BASE - 1;
        for (int n = 0; n < 4; n++) begin
            unmapped_access(holes[n], 1'b1, 32'hDEAD_BEEF);
            unmapped_access(holes[n], 1'b0, 32'h0);
        end
        ram_read_check(0);
        ram_read_check(RAM_WORDS - 1);
        seg_read_check(1'b0);
        seg_read_check(1'b1);
    endtask

    // Data pool is words 4096 to 4111, away from the code region.
    task automatic random_data_access();
        int unsigned kind;
        int unsigned idx;
        logic        we;
        logic [31:0] dat;
        logic [3:0]  sel;
        kind = $urandom_range(0, 3);
        idx  = $urandom_range(0, 15);
        we   = $urandom_range(0, 1);
        dat  = $urandom;
        sel  = $urandom_range(1, 15);
        case (kind)
            0, 1: begin
                if (we) begin
                    ram_write(4096 + idx, dat, sel);
                end else begin
                    ram_read_check(4096 + idx);
                end
            end
            2: begin
                if (we) begin
                    seg_write(idx[0], dat, sel);
                end else begin
                    seg_read_check(idx[0]);
                end
            end
            default: begin
                unmapped_access(32'h8000_0000 | $urandom, we, dat);
            end
        endcase
    endtask

    task automatic fetch_stream();
        int unsigned n;
        n = 0;
        while (!traffic_done && n < 1000) begin
            fetch_check(16 + n % 8);
            n++;
        end
        if (!traffic_done) begin
            stop_on_failure("The fetch stream ran past its limit before data traffic ended.");
        end
    endtask

    task automatic mixed_traffic();
        for (int n = 0; n < 16; n++) begin
            ram_write(4096 + n, $urandom, 4'hF);
        end
        traffic_done = 1'b0;
        fork
            begin
                for (int n = 0; n < 200; n++) begin
                    random_data_access();
                end
                traffic_done = 1'b1;
            end
            fetch_stream();
        join
    endtask

    initial begin
        void'($urandom(32'ha2e3));
        reset    = 1'b1;
        dbus_req = '0;
        ibus_req = '0;
        repeat (16) @(posedge clk);
        #1;
        reset_state();
        ram_access_sweep();
        fetch_after_write();
        display_registers();
        unmapped_space();
        mixed_traffic();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    // 10 ns period.
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== source/tenyr_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tenyr_soc (
    input  wire                clk,
    input  wire                reset_i,

    // Data master.
    input  wire tenyr_pkg::wb_req_t dbus_req_i,
    output tenyr_pkg::wb_rsp_t      dbus_rsp_o,

    // Instruction fetch master, read only.
    input  wire tenyr_pkg::wb_req_t ibus_req_i,
    output tenyr_pkg::wb_rsp_t      ibus_rsp_o,

    // Scanned seven-segment display.
    output logic [7:0]         seg_o,
    output logic [3:0]         an_o
);

    import tenyr_pkg::*;

    wb_req_t ram_req;
    wb_rsp_t ram_rsp;
    wb_req_t seg_req;
    wb_rsp_t seg_rsp;

    // Data bus split between RAM and display.
    wb_decoder decoder (
        .clk       ( clk        ),
        .reset_i   ( reset_i    ),
        .m_req_i   ( dbus_req_i ),
        .m_rsp_o   ( dbus_rsp_o ),
        .ram_req_o ( ram_req    ),
        .ram_rsp_i ( ram_rsp    ),
        .seg_req_o ( seg_req    ),
        .seg_rsp_i ( seg_rsp    )
    );

    // Port A serves data, port B serves fetch.
    block_ram ram (
        .clk     ( clk        ),
        .a_req_i ( ram_req    ),
        .a_rsp_o ( ram_rsp    ),
        .b_req_i ( ibus_req_i ),
        .b_rsp_o ( ibus_rsp_o ),
        .reset_i ( reset_i    )
    );

    seg7_display seg7 (
        .clk     ( clk     ),
        .reset_i ( reset_i ),
        .req_i   ( seg_req ),
        .rsp_o   ( seg_rsp ),
        .seg_o   ( seg_o   ),
        .an_o    ( an_o    )
    );

endmodule

`default_nettype wire

// ==== display/seg7_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7_display (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire tenyr_pkg::wb_req_t req_i,
    output tenyr_pkg::wb_rsp_t      rsp_o,
    output logic [7:0]              seg_o,
    output logic [3:0]              an_o
);

    import tenyr_pkg::*;

    logic [15:0]              value_q;
    logic [7:0]               ctrl_q;
    logic                     ack_q;
    logic [31:0]              rdata_q;
    logic                     bus_go;
    logic [SCAN_DIV_BITS+1:0] scan_q;
    logic [1:0]               digit;
    logic [3:0]               nibble;

    assign bus_go = req_i.stb && req_i.cyc && !ack_q;

    // Register writes land on the edge that raises ack.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            value_q <= '0;
            ctrl_q  <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= bus_go;
            if (bus_go && req_i.we) begin
                if (req_i.adr[0]) begin
                    if (req_i.sel[0]) begin
                        ctrl_q <= req_i.dat[7:0];
                    end
                end else begin
                    if (req_i.sel[0]) begin
                        value_q[7:0] <= req_i.dat[7:0];
                    end
                    if (req_i.sel[1]) begin
                        value_q[15:8] <= req_i.dat[15:8];
                    end
                end
            end
        end
    end

    // Read back, zero extended.
    always_ff @(posedge clk) begin
        if (bus_go) begin
            if (req_i.adr[0]) begin
                rdata_q <= {24'b0, ctrl_q};
            end else begin
                rdata_q <= {16'b0, value_q};
            end
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;

    // Top two bits of the scan counter select the digit.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            scan_q <= '0;
        end else begin
            scan_q <= scan_q + 1'b1;
        end
    end

    assign digit  = scan_q[SCAN_DIV_BITS +: 2];
    assign nibble = value_q[4*digit +: 4];

    // Enable bits are active low, so a cleared control shows every digit.
    always_comb begin
        an_o = 4'hF;
        if (!ctrl_q[digit]) begin
            an_o[digit] = 1'b0;
        end
    end

    // Decimal point sits in bit 7 and is active low too.
    assign seg_o = {~ctrl_q[4 + digit], seg7_font(nibble)};

    // Never more than one anode driven.
    a_one_anode: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(~an_o));

endmodule

`default_nettype wire

// ==== memory/block_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_ram (
    input  wire                     clk,
    input  wire tenyr_pkg::wb_req_t a_req_i,
    output tenyr_pkg::wb_rsp_t      a_rsp_o,
    input  wire tenyr_pkg::wb_req_t b_req_i,
    output tenyr_pkg::wb_rsp_t      b_rsp_o,
    input  wire                     reset_i
);

    import tenyr_pkg::*;

    logic [31:0]          mem [RAM_WORDS];
    logic [RAM_ABITS-1:0] a_idx;
    logic [RAM_ABITS-1:0] b_idx;
    logic                 a_go;
    logic                 b_go;
    logic                 a_ack_q;
    logic                 b_ack_q;
    logic [31:0]          a_dat_q;
    logic [31:0]          b_dat_q;

    assign a_idx = a_req_i.adr[RAM_ABITS-1:0];
    assign b_idx = b_req_i.adr[RAM_ABITS-1:0];

    // A held strobe is served once, then skipped on its ack cycle.
    assign a_go = a_req_i.stb && a_req_i.cyc && !a_ack_q;
    assign b_go = b_req_i.stb && b_req_i.cyc && !b_ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            a_ack_q <= 1'b0;
            b_ack_q <= 1'b0;
        end else begin
            a_ack_q <= a_go;
            b_ack_q <= b_go;
        end
    end

    // Port A, read-first with per-lane writes.
    always_ff @(posedge clk) begin
        if (a_go) begin
            a_dat_q <= mem[a_idx];
            if (a_req_i.we) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (a_req_i.sel[lane]) begin
                        mem[a_idx][8*lane +: 8] <= a_req_i.dat[8*lane +: 8];
                    end
                end
            end
        end
    end

    // Port B is fetch only.
    always_ff @(posedge clk) begin
        if (b_go) begin
            b_dat_q <= mem[b_idx];
        end
    end

    assign a_rsp_o.dat = a_dat_q;
    assign a_rsp_o.ack = a_ack_q;
    assign b_rsp_o.dat = b_dat_q;
    assign b_rsp_o.ack = b_ack_q;

    // Each ack answers a strobe seen one cycle earlier.
    a_ack_a_has_stb: assert property (@(posedge clk) disable iff (reset_i)
        a_rsp_o.ack |-> $past(a_req_i.stb && a_req_i.cyc));

    a_ack_b_has_stb: assert property (@(posedge clk) disable iff (reset_i)
        b_rsp_o.ack |-> $past(b_req_i.stb && b_req_i.cyc));

endmodule

`default_nettype wire

// ==== source/wb_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_decoder (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire tenyr_pkg::wb_req_t m_req_i,
    output tenyr_pkg::wb_rsp_t      m_rsp_o,
    output tenyr_pkg::wb_req_t      ram_req_o,
    input  wire tenyr_pkg::wb_rsp_t ram_rsp_i,
    output tenyr_pkg::wb_req_t      seg_req_o,
    input  wire tenyr_pkg::wb_rsp_t seg_rsp_i
);

    import tenyr_pkg::*;

    dec_target_e tgt;
    dec_target_e tgt_q;
    logic        m_active;
    logic        none_ack_q;

    assign m_active = m_req_i.stb && m_req_i.cyc;

    // Address match against the map.
    always_comb begin
        if ((m_req_i.adr & RAM_MASK) == RAM_BASE) begin
            tgt = TGT_RAM;
        end else if ((m_req_i.adr & SEG7_MASK) == SEG7_BASE) begin
            tgt = TGT_SEG7;
        end else begin
            tgt = TGT_NONE;
        end
    end

    // Only the selected slave sees the strobe.
    always_comb begin
        ram_req_o     = m_req_i;
        ram_req_o.stb = m_req_i.stb && (tgt == TGT_RAM);
        ram_req_o.cyc = m_req_i.cyc && (tgt == TGT_RAM);
        seg_req_o     = m_req_i;
        seg_req_o.stb = m_req_i.stb && (tgt == TGT_SEG7);
        seg_req_o.cyc = m_req_i.cyc && (tgt == TGT_SEG7);
    end

    // Target of last cycle picks the response, which lines up with the slave ack.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            tgt_q      <= TGT_NONE;
            none_ack_q <= 1'b0;
        end else begin
            tgt_q      <= tgt;
            none_ack_q <= m_active && (tgt == TGT_NONE) && !none_ack_q;
        end
    end

    // Unmapped space acks with zero data.
    always_comb begin
        case (tgt_q)
            TGT_RAM: begin
                m_rsp_o = ram_rsp_i;
            end
            TGT_SEG7: begin
                m_rsp_o = seg_rsp_i;
            end
            default: begin
                m_rsp_o.dat = '0;
                m_rsp_o.ack = none_ack_q;
            end
        endcase
    end

    // At most one slave answers, and only the one that was decoded.
    a_one_slave: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0({ram_rsp_i.ack, seg_rsp_i.ack, none_ack_q}) &&
        (!ram_rsp_i.ack || (tgt_q == TGT_RAM)) &&
        (!seg_rsp_i.ack || (tgt_q == TGT_SEG7)));

    // Whatever the slave, a new request is acked on the next cycle.
    a_ack_next: assert property (@(posedge clk) disable iff (reset_i)
        (m_active && !m_rsp_o.ack) |=> m_rsp_o.ack);

endmodule

`default_nettype wire

// ==== common/tenyr_pkg.sv ====
`default_nettype none

package tenyr_pkg;

    // Request from a bus master to a slave.
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic [3:0]  sel;
        logic        stb;
        logic        cyc;
    } wb_req_t;

    // Response from a slave back to its master.
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        TGT_RAM  = 2'd0,
        TGT_SEG7 = 2'd1,
        TGT_NONE = 2'd2
    } dec_target_e;

    // Address map, all in words.
    localparam int unsigned RAM_ABITS = 13;
    localparam int unsigned RAM_WORDS = 1 << RAM_ABITS;
    localparam logic [31:0] RAM_BASE  = 32'h0000_2000;
    localparam logic [31:0] RAM_MASK  = 32'hFFFF_E000;
    localparam logic [31:0] SEG7_BASE = 32'h0000_0100;
    localparam logic [31:0] SEG7_MASK = 32'hFFFF_FFFE;

    // Display scan rate.
    localparam int unsigned SCAN_DIV_BITS = 4;

    // Hex digit to segments, active low, bit order gfedcba.
    function automatic logic [6:0] seg7_font(input logic [3:0] nibble);
        logic [6:0] pat;
        case (nibble)
            4'h0: pat = 7'h40;
            4'h1: pat = 7'h79;
            4'h2: pat = 7'h24;
            4'h3: pat = 7'h30;
            4'h4: pat = 7'h19;
            4'h5: pat = 7'h12;
            4'h6: pat = 7'h02;
            4'h7: pat = 7'h78;
            4'h8: pat = 7'h00;
            4'h9: pat = 7'h10;
            4'hA: pat = 7'h08;
            4'hB: pat = 7'h03;
            4'hC: pat = 7'h46;
            4'hD: pat = 7'h21;
            4'hE: pat = 7'h06;
            default: pat = 7'h0E;
        endcase
        return pat;
    endfunction

endpackage

`default_nettype wire
